// File: design/rms_norm_config.svh
/*
  RMS norm configuration
  Frame geometry and fixed-point formats shared by the design
*/

`ifndef RMS_NORM_CONFIG_SVH
`define RMS_NORM_CONFIG_SVH

// Frame geometry
`define LANES        4
`define BEATS        4
`define FRAME_SHIFT  4
`define FIFO_DEPTH   8

// Fixed-point formats
`define SAMPLE_W     8
`define SAMPLE_FRAC  2
`define OUT_W        8
`define OUT_FRAC     4
`define ACC_W        20
`define MEAN_W       16
`define MEAN_FRAC    4
`define ROOT_W       8
`define ROOT_FRAC    (`MEAN_FRAC / 2)
`define FACTOR_W     16
`define FACTOR_FRAC  12

`endif

// File: design/rms_norm_pkg.sv
/*
  RMS norm types
  Sample, beat, mean and factor formats used across the engine
*/

`include "rms_norm_config.svh"

package rms_norm_pkg;

    // One input sample, 2 fraction bits
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // One output sample, 4 fraction bits
    typedef logic signed [`OUT_W-1:0] out_sample_t;

    typedef struct packed {
        sample_t [`LANES-1:0] lane;
    } in_beat_t;

    typedef struct packed {
        out_sample_t [`LANES-1:0] lane;
    } out_beat_t;

    // Clamped mean square, unsigned
    typedef logic [`MEAN_W-1:0] mean_t;

    // Inverse RMS, unsigned with 12 fraction bits
    typedef logic [`FACTOR_W-1:0] factor_t;

endpackage

// File: design/beat_fifo.sv
/*
  Beat FIFO
  Holds raw input beats until the scale factor of their frame is ready
*/

`timescale 1ns/1ps
`include "rms_norm_config.svh"

module beat_fifo
    import rms_norm_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  in_beat_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output in_beat_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    in_beat_t         mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != (PTR_W+1)'(`FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Depth is a power of two so pointers wrap on their own
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

endmodule

// File: design/square_sum.sv
/*
  Square sum
  Squares and accumulates one frame, then emits the clamped mean square
*/

`timescale 1ns/1ps
`include "rms_norm_config.svh"

module square_sum
    import rms_norm_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  in_beat_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output mean_t    mean_data,
    output logic     mean_valid,
    input  logic     mean_ready
);

    localparam int CNT_W = $clog2(`BEATS);
    localparam int SQ_W  = 2 * `SAMPLE_W;

    logic [`ACC_W-1:0]        acc;
    logic [`ACC_W-1:0]        beat_sum;
    logic [`ACC_W-1:0]        total;
    logic [`ACC_W-1:0]        shifted;
    logic signed [SQ_W-1:0]   sq [`LANES];
    logic [CNT_W-1:0]         beat_cnt;
    logic                     accept;
    logic                     last_beat;
    mean_t                    clamped;

    // Square of a signed sample is never negative
    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < `LANES; i++) begin
            sq[i]    = $signed(in_data.lane[i]) * $signed(in_data.lane[i]);
            beat_sum = beat_sum + `ACC_W'($unsigned(sq[i]));
        end
    end

    assign total     = acc + beat_sum;
    assign shifted   = total >> `FRAME_SHIFT;
    assign clamped   = (shifted > `ACC_W'({`MEAN_W{1'b1}})) ? '1 : shifted[`MEAN_W-1:0];
    assign in_ready  = ~mean_valid;
    assign accept    = in_valid & in_ready;
    assign last_beat = (beat_cnt == CNT_W'(`BEATS-1));

    always_ff @(posedge clk) begin
        if (rst) begin
            acc        <= '0;
            beat_cnt   <= '0;
            mean_valid <= 1'b0;
        end else begin
            if (mean_valid && mean_ready) mean_valid <= 1'b0;
            if (accept) begin
                acc      <= last_beat ? '0 : total;
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) mean_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && last_beat) mean_data <= clamped;
    end

endmodule

// File: design/inv_sqrt.sv
/*
  Inverse square root
  Bit-serial integer root of the mean, then a restoring divide of 2^14 by it
*/

`timescale 1ns/1ps
`include "rms_norm_config.svh"

module inv_sqrt
    import rms_norm_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  mean_t   mean_data,
    input  logic    mean_valid,
    output logic    mean_ready,
    output factor_t factor_data,
    output logic    factor_valid,
    input  logic    factor_ready
);

    typedef enum logic [1:0] {S_IDLE, S_ROOT, S_DIV, S_DONE} state_t;

    // 1 / (r / 4) with 12 fraction bits is 2^14 / r
    localparam factor_t NUMER = factor_t'(1) << (`FACTOR_FRAC + `ROOT_FRAC);

    state_t                state;
    mean_t                 mean_q;
    logic [`ROOT_W-1:0]    root;
    logic [`ROOT_W-1:0]    trial;
    logic [2*`ROOT_W-1:0]  trial_sq;
    logic [3:0]            step;
    factor_t               dividend;
    factor_t               quot;
    logic [`ROOT_W:0]      rem;
    logic [`ROOT_W:0]      rem_shift;
    logic                  fits;

    assign trial     = root | (`ROOT_W'(1) << step[2:0]);
    assign trial_sq  = trial * trial;
    assign rem_shift = {rem[`ROOT_W-1:0], dividend[`FACTOR_W-1]};
    assign fits      = (rem_shift >= {1'b0, root});

    assign mean_ready   = (state == S_IDLE);
    assign factor_valid = (state == S_DONE);
    // Quotient is at most 2^14, only a zero root needs the clamp
    assign factor_data  = (root == '0) ? '1 : quot;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (mean_valid) state <= S_ROOT;
                S_ROOT: if (step == 4'd0) state <= S_DIV;
                S_DIV:  if (step == 4'd0) state <= S_DONE;
                S_DONE: if (factor_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                mean_q <= mean_data;
                root   <= '0;
                step   <= 4'(`ROOT_W-1);
            end
            S_ROOT: begin
                // Keep the trial bit if its square still fits under the mean
                if (trial_sq <= mean_q) root <= trial;
                step     <= (step == 4'd0) ? 4'(`FACTOR_W-1) : step - 1'b1;
                rem      <= '0;
                quot     <= '0;
                dividend <= NUMER;
            end
            S_DIV: begin
                rem      <= fits ? rem_shift - {1'b0, root} : rem_shift;
                quot     <= {quot[`FACTOR_W-2:0], fits};
                dividend <= dividend << 1;
                step     <= step - 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: design/norm_scale.sv
/*
  Normalize and scale
  Applies one factor to four stored beats, floors, saturates and registers
*/

`timescale 1ns/1ps
`include "rms_norm_config.svh"

module norm_scale
    import rms_norm_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  in_beat_t  beat_data,
    input  logic      beat_valid,
    output logic      beat_ready,
    input  factor_t   factor_data,
    input  logic      factor_valid,
    output logic      factor_ready,
    output out_beat_t out_data,
    output logic      out_valid,
    input  logic      out_ready
);

    localparam int USE_W  = $clog2(`BEATS);
    localparam int PROD_W = `SAMPLE_W + `FACTOR_W + 1;
    localparam int SHIFT  = `SAMPLE_FRAC + `FACTOR_FRAC - `OUT_FRAC;
    localparam logic signed [PROD_W-1:0] MAX_OUT = (1 <<< (`OUT_W-1)) - 1;
    localparam logic signed [PROD_W-1:0] MIN_OUT = -(1 <<< (`OUT_W-1));

    factor_t                   fac;
    logic                      fac_loaded;
    logic [USE_W-1:0]          uses_left;
    logic                      advance;
    logic                      fire;
    logic signed [PROD_W-1:0]  prod [`LANES];
    logic signed [PROD_W-1:0]  floored [`LANES];
    out_beat_t                 scaled;

    assign factor_ready = ~fac_loaded;
    assign advance      = ~out_valid | out_ready;
    assign beat_ready   = fac_loaded & advance;
    assign fire         = fac_loaded & beat_valid & advance;

    always_comb begin
        for (int i = 0; i < `LANES; i++) begin
            prod[i]    = $signed(beat_data.lane[i]) * $signed({1'b0, fac});
            // Arithmetic shift floors toward minus infinity
            floored[i] = prod[i] >>> SHIFT;
            if (floored[i] > MAX_OUT)      scaled.lane[i] = MAX_OUT[`OUT_W-1:0];
            else if (floored[i] < MIN_OUT) scaled.lane[i] = MIN_OUT[`OUT_W-1:0];
            else                           scaled.lane[i] = floored[i][`OUT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fac_loaded <= 1'b0;
            uses_left  <= '0;
            out_valid  <= 1'b0;
        end else begin
            if (factor_valid && factor_ready) begin
                fac_loaded <= 1'b1;
                uses_left  <= USE_W'(`BEATS-1);
            end else if (fire) begin
                if (uses_left == '0) fac_loaded <= 1'b0;
                uses_left <= uses_left - 1'b1;
            end
            if (advance) out_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (factor_valid && factor_ready) fac <= factor_data;
        if (fire) out_data <= scaled;
    end

endmodule

// File: design/rms_norm.sv
/*
  RMS normalization engine
  Splits the input to a beat store and a mean-square path, then rescales
*/

`timescale 1ns/1ps

module rms_norm
    import rms_norm_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  in_beat_t  in_data,
    input  logic      in_valid,
    output logic      in_ready,
    output out_beat_t out_data,
    output logic      out_valid,
    input  logic      out_ready
);

    logic     fifo_in_ready;
    logic     sum_in_ready;
    in_beat_t fifo_data;
    logic     fifo_valid;
    logic     fifo_ready;
    mean_t    mean_data;
    logic     mean_valid;
    logic     mean_ready;
    factor_t  factor_data;
    logic     factor_valid;
    logic     factor_ready;

    // Both branches take a beat in the same cycle or neither does
    assign in_ready = fifo_in_ready & sum_in_ready;

    beat_fifo i_beat_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid & sum_in_ready),
        .in_ready  (fifo_in_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    square_sum i_square_sum (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .in_valid   (in_valid & fifo_in_ready),
        .in_ready   (sum_in_ready),
        .mean_data  (mean_data),
        .mean_valid (mean_valid),
        .mean_ready (mean_ready)
    );

    inv_sqrt i_inv_sqrt (
        .clk          (clk),
        .rst          (rst),
        .mean_data    (mean_data),
        .mean_valid   (mean_valid),
        .mean_ready   (mean_ready),
        .factor_data  (factor_data),
        .factor_valid (factor_valid),
        .factor_ready (factor_ready)
    );

    norm_scale i_norm_scale (
        .clk          (clk),
        .rst          (rst),
        .beat_data    (fifo_data),
        .beat_valid   (fifo_valid),
        .beat_ready   (fifo_ready),
        .factor_data  (factor_data),
        .factor_valid (factor_valid),
        .factor_ready (factor_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

// File: bench/tb_clock.sv
/*
  Testbench clock and reset
  10 ns clock, reset held high for the first 3 rising edges
*/

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: bench/rms_norm_checker.sv
/*
  RMS norm checker
  Models the fixed-point arithmetic from the input transfers and compares
  every output transfer in order, one report line per frame
*/

`timescale 1ns/1ps
`include "rms_norm_config.svh"

module rms_norm_checker
    import rms_norm_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  in_beat_t  in_data,
    input  logic      in_valid,
    input  logic      in_ready,
    input  out_beat_t out_data,
    input  logic      out_valid,
    input  logic      out_ready,
    input  logic      exp_known,
    input  out_beat_t exp_beat,
    output int        frames_done,
    output int        errors
);

    int        samples [`BEATS * `LANES];
    out_beat_t model_q [$];
    out_beat_t table_q [$];
    logic      known_q [$];
    int        in_cnt;
    int        out_cnt;
    int        frame_bad;

    // Mean of squares, integer root, then 2^14 / root
    function automatic int inv_rms_factor(input int sum);
        int mean;
        int r;
        mean = sum >>> 4;
        if (mean > 65535) mean = 65535;
        r = 0;
        while ((r + 1) * (r + 1) <= mean) r++;
        if (r == 0) return 65535;
        return (16384 / r > 65535) ? 65535 : 16384 / r;
    endfunction

    // Floor by arithmetic shift, then saturate to 8 bits
    function automatic logic [7:0] scale_sample(input int s, input int factor);
        int v;
        v = (s * factor) >>> 10;
        if (v > 127) v = 127;
        else if (v < -128) v = -128;
        return 8'(v);
    endfunction

    task automatic push_frame();
        int        sum;
        int        factor;
        out_beat_t beat;
        sum = 0;
        foreach (samples[k]) sum += samples[k] * samples[k];
        factor = inv_rms_factor(sum);
        for (int b = 0; b < `BEATS; b++) begin
            for (int l = 0; l < `LANES; l++)
                beat.lane[l] = scale_sample(samples[b * `LANES + l], factor);
            model_q.push_back(beat);
        end
    endtask

    task automatic check_beat();
        out_beat_t want;
        out_beat_t listed;
        logic      known;
        if (model_q.size() == 0) begin
            $display("Output beat arrived while no input frame was pending");
            errors++;
        end else begin
            want   = model_q.pop_front();
            listed = table_q.pop_front();
            known  = known_q.pop_front();
            if (out_data !== want) begin
                $display("Error: out_data frame %0d beat %0d expected %h actual %h",
                         frames_done, out_cnt, want, out_data);
                frame_bad++;
                errors++;
            end else if (known && out_data !== listed) begin
                $display("Error: out_data frame %0d beat %0d table value %h actual %h",
                         frames_done, out_cnt, listed, out_data);
                frame_bad++;
                errors++;
            end
            out_cnt++;
            if (out_cnt == `BEATS) begin
                if (frame_bad == 0)
                    $display("Frame %0d: all %0d beats match", frames_done, `BEATS);
                else
                    $display("Frame %0d: %0d beats wrong", frames_done, frame_bad);
                frame_bad = 0;
                out_cnt   = 0;
                frames_done++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            in_cnt      = 0;
            out_cnt     = 0;
            frame_bad   = 0;
            frames_done = 0;
            errors      = 0;
            model_q.delete();
            table_q.delete();
            known_q.delete();
        end else begin
            if (in_valid && in_ready) begin
                for (int l = 0; l < `LANES; l++)
                    samples[in_cnt * `LANES + l] = $signed(in_data.lane[l]);
                table_q.push_back(exp_beat);
                known_q.push_back(exp_known);
                in_cnt++;
                if (in_cnt == `BEATS) begin
                    push_frame();
                    in_cnt = 0;
                end
            end
            if (out_valid && out_ready) check_beat();
        end
    end

endmodule

// File: bench/rms_norm_sva.sv
/*
  Stream handshake assertions
  Bound into the RMS norm top level
*/

`timescale 1ns/1ps

module rms_norm_sva
    import rms_norm_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input in_beat_t  in_data,
    input logic      in_valid,
    input logic      in_ready,
    input out_beat_t out_data,
    input logic      out_valid,
    input logic      out_ready
);

    // A stalled source keeps valid and data until the transfer
    in_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else $error("in_data changed or in_valid dropped before its transfer");

    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_data changed or out_valid dropped before its transfer");

    out_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high during reset");

endmodule

bind rms_norm rms_norm_sva i_sva (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

// File: bench/rms_norm_tb.sv
/*
  RMS norm testbench
  Applies a table of frames on the falling edge, with optional output
  stalls, and reports the checker's results
*/

`timescale 1ns/1ps
`include "rms_norm_config.svh"

module rms_norm_tb
    import rms_norm_pkg::*;
();

    localparam int NF         = 11;
    localparam int FRAME_LEN  = `BEATS * `LANES;
    localparam int WAIT_LIMIT = 5000;

    logic      clk;
    logic      rst;
    in_beat_t  in_data;
    logic      in_valid;
    logic      in_ready;
    out_beat_t out_data;
    logic      out_valid;
    logic      out_ready;
    logic      exp_known;
    out_beat_t exp_beat;
    logic      stall_on;
    logic      timed_out;
    int        frames_done;
    int        errors;
    int        seed;

    // One row per frame with samples, expected beats where known and stall mode
    sample_t   tab_sample [NF][FRAME_LEN];
    out_beat_t tab_exp    [NF][`BEATS];
    logic      tab_known  [NF];
    logic      tab_stall  [NF];

    tb_clock i_clock (
        .clk (clk),
        .rst (rst)
    );

    rms_norm i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    rms_norm_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .exp_known   (exp_known),
        .exp_beat    (exp_beat),
        .frames_done (frames_done),
        .errors      (errors)
    );

    // Frame 0 constant 4.0, frame 1 zero, frame 2 spike, 3 to 6 random, 7 to 10 stalled
    task automatic build_table();
        for (int f = 0; f < NF; f++) begin
            tab_known[f] = (f < 3);
            tab_stall[f] = (f >= 7);
            for (int k = 0; k < FRAME_LEN; k++) begin
                if (f == 0)     tab_sample[f][k] = 8'sd16;
                else if (f < 3) tab_sample[f][k] = '0;
                else            tab_sample[f][k] = sample_t'($random(seed));
            end
            for (int b = 0; b < `BEATS; b++)
                tab_exp[f][b] = (f == 0) ? 32'h10101010 : '0;
        end
        // Mean rounds to zero, so 0.75 saturates and -0.25 floors to -4.0
        tab_sample[2][0] = 8'sd3;
        tab_sample[2][1] = -8'sd1;
        tab_sample[2][2] = -8'sd2;
        tab_exp[2][0]    = 32'h0080c07f;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        @(negedge clk);
        while (rst && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: reset was never released");
                timed_out = 1'b1;
            end
        end
    endtask

    // Called just after a falling edge and holds the beat until it is taken
    task automatic send_beat(input int f, input int b);
        int waited;
        waited = 0;
        for (int l = 0; l < `LANES; l++)
            in_data.lane[l] = tab_sample[f][b * `LANES + l];
        exp_beat  = tab_exp[f][b];
        exp_known = tab_known[f];
        in_valid  = 1'b1;
        // in_ready comes from registers only, so it holds until the rising edge
        while (!in_ready && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: frame %0d beat %0d was never accepted", f, b);
                timed_out = 1'b1;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (frames_done < NF && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: only %0d of %0d frames came out", frames_done, NF);
                timed_out = 1'b1;
            end
        end
    endtask

    // Output back-pressure is random while the current frame asks for stalls
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (stall_on) out_ready = (($random(seed) & 32'd3) != 0);
            else          out_ready = 1'b1;
        end
    end

    initial begin
        seed      = 32'h4c476c5c;
        in_data   = '0;
        in_valid  = 1'b0;
        exp_known = 1'b0;
        exp_beat  = '0;
        stall_on  = 1'b0;
        timed_out = 1'b0;
        build_table();
        wait_reset_release();
        for (int f = 0; f < NF && !timed_out; f++) begin
            stall_on <= tab_stall[f];
            for (int b = 0; b < `BEATS && !timed_out; b++)
                send_beat(f, b);
        end
        wait_results();
        $display("Frames checked: %0d of %0d, errors: %0d", frames_done, NF, errors);
        if (timed_out || errors != 0 || frames_done != NF) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design
design/rms_norm_pkg.sv
design/beat_fifo.sv
design/square_sum.sv
design/inv_sqrt.sv
design/norm_scale.sv
design/rms_norm.sv
bench/tb_clock.sv
bench/rms_norm_checker.sv
bench/rms_norm_sva.sv
bench/rms_norm_tb.sv

// File: run.sh
#!/bin/sh
# Build the RMS norm testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module rms_norm_tb -o rms_norm_sim -f vlog.f \
    || { echo "Build failed"; exit 1; }
result=$(./obj_dir/rms_norm_sim)
echo "$result"
echo "$result" | grep -q "All checks passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
